// ==== common/loggerPkg.sv ====
// sector logger shared definitions
// width types, writer state encoding and the
// FAT short directory entry constants

package loggerPkg;

  // ------------------------------
  // width types
  // ------------------------------
  typedef logic [7:0]  byteT;
  // device sector address
  typedef logic [31:0] sectorAddrT;
  // file length in bytes, as stored in the entry
  typedef logic [31:0] fileLenT;
  // byte index inside a sector, up to 512 bytes
  typedef logic [8:0]  sectorIdxT;
  // fifo fill level, depths up to 2048
  typedef logic [11:0] fifoCountT;

  // writer sequencer states
  typedef enum logic [1:0] {
    idle       = 2'd0,
    dataSector = 2'd1,
    dirSector  = 2'd2
  } writerStateT;

  // ------------------------------
  // directory entry layout
  // ------------------------------
  localparam int   dirEntryBytes = 32;
  localparam byteT attrArchive   = 8'h20;
  // 8.3 name, space padded
  localparam int   shortNameLen  = 11;

endpackage

// ==== filelist.f ====
common/loggerPkg.sv
verilog/uartRx.sv
verilog/byteFifo.sv
sectorWriter/dirEntryBuilder.sv
sectorWriter/sectorWriter.sv
verilog/sdFileLogger.sv
tests/clockGen.sv
tests/sdFileLogger_sva.sv
tests/tbSdFileLogger.sv

// ==== runSim.sh ====
#!/bin/bash
# build the sector logger testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tbSdFileLogger \
  -f filelist.f -Mdir obj_dir > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/VtbSdFileLogger > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sectorWriter/dirEntryBuilder.sv ====
// directory sector content
// returns one byte of the sector holding the file's FAT short
// entry at offset 0, the rest of the sector reads as zero

`timescale 1ns/1ps

module dirEntryBuilder
  import loggerPkg::*;
#(
  parameter logic [8*shortNameLen-1:0] shortName    = "SAVEDATADAT",
  parameter logic [31:0]               startCluster = 32'd5
) (
  input  sectorIdxT entryIdx,
  input  fileLenT   fileLen,
  output byteT      entryByte
);

  localparam sectorIdxT nameEnd  = sectorIdxT'(shortNameLen);
  localparam sectorIdxT entryEnd = sectorIdxT'(dirEntryBytes);

  // name is stored first char in the top byte
  logic [3:0] nameSel;

  assign nameSel = 4'(shortNameLen - 1) - entryIdx[3:0];

  always_comb begin
    entryByte = '0;
    if (entryIdx < nameEnd) begin
      // bytes 0..10, 8.3 name
      entryByte = shortName[nameSel*8 +: 8];
    end else if (entryIdx < entryEnd) begin
      case (entryIdx[4:0])
        5'd11: entryByte = attrArchive;
        // cluster high half
        5'd20: entryByte = startCluster[23:16];
        5'd21: entryByte = startCluster[31:24];
        // cluster low half
        5'd26: entryByte = startCluster[7:0];
        5'd27: entryByte = startCluster[15:8];
        // file size, little endian
        5'd28: entryByte = fileLen[7:0];
        5'd29: entryByte = fileLen[15:8];
        5'd30: entryByte = fileLen[23:16];
        5'd31: entryByte = fileLen[31:24];
        // times, dates and reserved fields stay zero
        default: entryByte = '0;
      endcase
    end
  end

endmodule

// ==== sectorWriter/sectorWriter.sv ====
// sector writer
// pops a full sector from the FIFO onto the sector write port,
// then every updateInterval data sectors rewrites the directory
// sector with the current file length

`timescale 1ns/1ps

module sectorWriter
  import loggerPkg::*;
#(
  parameter int                        sectorBytes     = 512,
  parameter sectorAddrT                dataStartSector = 32'h0000_2000,
  parameter sectorAddrT                dirSector       = 32'h0000_1000,
  parameter int                        updateInterval  = 8,
  parameter logic [8*shortNameLen-1:0] shortName       = "SAVEDATADAT",
  parameter logic [31:0]               startCluster    = 32'd5
) (
  input  logic       clk,
  input  logic       rstn,
  input  fifoCountT  fillCount,
  input  byteT       popData,
  output logic       pop,
  output logic       sectorStart,
  output sectorAddrT sectorAddr,
  output logic       byteValid,
  output byteT       byteData
);

  localparam sectorIdxT lastIdx   = sectorIdxT'(sectorBytes - 1);
  localparam fifoCountT threshold = fifoCountT'(sectorBytes);
  localparam int        intW      = (updateInterval > 1) ? $clog2(updateInterval) : 1;
  localparam logic [intW-1:0] intLast = intW'(updateInterval - 1);

  writerStateT     state;
  logic            issue;
  sectorIdxT       idx;
  logic            lastByte;
  logic            countDone;
  logic            dirDue;
  logic            outDir;
  sectorIdxT       entryIdx;
  sectorAddrT      nextDataAddr;
  fileLenT         sectorCount;
  logic [intW-1:0] intervalCnt;
  fileLenT         fileLen;
  byteT            entryByte;

  // fifo is only read for data sectors
  assign pop     = issue && (state == dataSector);
  assign fileLen = sectorCount * fileLenT'(sectorBytes);

  // ------------------------------
  // sequencer
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= idle;
      issue        <= 1'b0;
      idx          <= '0;
      sectorStart  <= 1'b0;
      sectorAddr   <= '0;
      nextDataAddr <= dataStartSector;
      sectorCount  <= '0;
      intervalCnt  <= '0;
      dirDue       <= 1'b0;
      countDone    <= 1'b0;
    end else begin
      sectorStart <= 1'b0;
      countDone   <= 1'b0;
      // byte index walks 0..sectorBytes-1 while issuing
      if (issue) begin
        if (idx == lastIdx) issue <= 1'b0;
        idx <= idx + 1'b1;
      end
      case (state)
        idle: begin
          if (fillCount >= threshold) begin
            state        <= dataSector;
            sectorStart  <= 1'b1;
            sectorAddr   <= nextDataAddr;
            nextDataAddr <= nextDataAddr + 1'b1;
            issue        <= 1'b1;
            idx          <= '0;
          end
        end
        dataSector: begin
          // last byte on the port, count the sector
          if (lastByte) begin
            sectorCount <= sectorCount + 1'b1;
            countDone   <= 1'b1;
            dirDue      <= (intervalCnt == intLast);
            intervalCnt <= (intervalCnt == intLast) ? '0 : intervalCnt + 1'b1;
          end
          if (countDone) begin
            if (dirDue) begin
              state       <= loggerPkg::dirSector;
              sectorStart <= 1'b1;
              sectorAddr  <= dirSector;
              issue       <= 1'b1;
              idx         <= '0;
            end else begin
              state <= idle;
            end
          end
        end
        loggerPkg::dirSector: begin
          if (lastByte) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // ------------------------------
  // output alignment
  // ------------------------------
  // one stage so fifo data and entry bytes meet byteValid
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      byteValid <= 1'b0;
      lastByte  <= 1'b0;
      outDir    <= 1'b0;
    end else begin
      byteValid <= issue;
      lastByte  <= issue && (idx == lastIdx);
      outDir    <= (state == loggerPkg::dirSector);
    end
  end

  always_ff @(posedge clk) begin
    entryIdx <= idx;
  end

  dirEntryBuilder #(
    .shortName   (shortName),
    .startCluster(startCluster)
  ) u_dirEntry (
    .entryIdx (entryIdx),
    .fileLen  (fileLen),
    .entryByte(entryByte)
  );

  assign byteData = outDir ? entryByte : popData;

endmodule

// ==== tests/clockGen.sv ====
// testbench clock and power-on reset
// free running clock, reset held low for the first cycles

`timescale 1ns/1ps

module clockGen #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // release on a rising edge, after resetCycles edges
  initial begin
    rstn = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

// ==== tests/sdFileLogger_sva.sv ====
// output strobe assertions for the sector logger
// bound into the top level, checks the sector write port

`timescale 1ns/1ps

module sdFileLoggerSva (
  input logic clk,
  input logic rstn,
  input logic sectorStart,
  input logic byteValid
);

  // failures seen so far, read by the testbench at the end
  int failCount = 0;

  // ------------------------------
  // strobe rules
  // ------------------------------
  // start and data never share a cycle
  startApartFromByte: assert property (
    @(posedge clk) disable iff (!rstn) !(sectorStart && byteValid)
  ) else begin
    failCount++;
    $error("sectorStart and byteValid high in the same cycle");
  end

  // start is a single cycle strobe
  startOneCycle: assert property (
    @(posedge clk) disable iff (!rstn) sectorStart |=> !sectorStart
  ) else begin
    failCount++;
    $error("sectorStart held high for more than one cycle");
  end

  // quiet port while in reset
  startLowInReset: assert property (
    @(posedge clk) !rstn |-> !sectorStart
  ) else begin
    failCount++;
    $error("sectorStart high during reset");
  end

endmodule

bind sdFileLogger sdFileLoggerSva u_sva (
  .clk        (clk),
  .rstn       (rstn),
  .sectorStart(sectorStart),
  .byteValid  (byteValid)
);

// ==== tests/tbSdFileLogger.sv ====
// sector logger testbench
// sends random UART bytes, follows every sector on the write port
// and checks data bytes, addresses and directory sector content

`timescale 1ns/1ps

module tbSdFileLogger
  import loggerPkg::*;
();

  localparam int          sectorBytes    = 64;
  localparam int          clksPerBit     = 8;
  localparam int          updateInterval = 2;
  localparam int          fifoDepthLog2  = 8;
  localparam sectorAddrT  dataStart      = 32'h0000_0800;
  localparam sectorAddrT  dirAddr        = 32'h0000_0400;
  localparam logic [31:0] cluster        = 32'h0012_0345;
  localparam logic [87:0] nameBits       = "LOGFILE TXT";
  localparam int          byteCycles     = 10 * clksPerBit;
  // every byte sent over all five tests
  localparam int totalBytes = sectorBytes + (sectorBytes - 1) + (2 * sectorBytes + 1)
                              + 2 * sectorBytes;
  localparam int timeoutCycles = totalBytes * 10 * clksPerBit * 2 + 2000;
  localparam int sectorWaitCycles = 8 * sectorBytes;

  logic clk, porRstn, swRstn, dutRstn, rx;
  logic sectorStart, byteValid;
  sectorAddrT sectorAddr;
  byteT byteData;

  // model state, owned by the compare process
  byteT expQ[$];
  int dirLenLog[$];
  int dataDone = 0, dirSeen = 0, startCount = 0, byteIdx = 0, sinceStart = 0;
  logic inSector = 1'b0, curIsDir = 1'b0, dirPending = 1'b0;
  sectorAddrT lastStartAddr = '0;
  // length field of the directory sector on the port
  logic [31:0] dirLenSeen = '0;
  int errorCount = 0, checkCount = 0, testsRun = 0, cycleCount = 0;

  assign dutRstn = porRstn && swRstn;

  clockGen #(.periodNs(8), .resetCycles(8)) u_clk (.clk(clk), .rstn(porRstn));

  sdFileLogger #(
    .clksPerBit     (clksPerBit),
    .fifoDepthLog2  (fifoDepthLog2),
    .sectorBytes    (sectorBytes),
    .dataStartSector(dataStart),
    .dirSector      (dirAddr),
    .updateInterval (updateInterval),
    .shortName      (nameBits),
    .startCluster   (cluster)
  ) u_dut (
    .clk        (clk),
    .rstn       (dutRstn),
    .rx         (rx),
    .sectorStart(sectorStart),
    .sectorAddr (sectorAddr),
    .byteValid  (byteValid),
    .byteData   (byteData)
  );

  // ------------------------------
  // checks and reference
  // ------------------------------
  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic reportFailure(input string what);
    errorCount++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  // FAT short entry at offset 0 of the directory sector
  function automatic byteT expectedDirByte(input int idx, input int sectors);
    logic [31:0] len;
    len = sectors * sectorBytes;
    // name, first character in the top byte of the literal
    if (idx < 11) return nameBits[8 * (10 - idx) +: 8];
    case (idx)
      11: return 8'h20;
      20: return cluster[23:16];
      21: return cluster[31:24];
      26: return cluster[7:0];
      27: return cluster[15:8];
      28: return len[7:0];
      29: return len[15:8];
      30: return len[23:16];
      31: return len[31:24];
      default: return 8'h00;
    endcase
  endfunction

  // ------------------------------
  // capture and compare
  // ------------------------------
  always @(posedge clk) begin
    if (!dutRstn) begin
      inSector   = 1'b0;
      byteIdx    = 0;
      dataDone   = 0;
      dirSeen    = 0;
      dirPending = 1'b0;
    end else begin
      if (inSector) sinceStart++;
      if (sectorStart) begin
        startCount++;
        if (inSector) reportFailure("sector started before the previous one was complete");
        inSector      = 1'b1;
        curIsDir      = (sectorAddr == dirAddr);
        byteIdx       = 0;
        sinceStart    = 0;
        lastStartAddr = sectorAddr;
        if (curIsDir) begin
          dirSeen++;
          dirLenSeen = '0;
          if (!dirPending) reportFailure("directory sector where no update was due");
        end else begin
          if (dirPending) reportFailure("directory sector missing after a data sector");
          checkValue("sectorAddr", sectorAddr, dataStart + dataDone);
        end
        dirPending = 1'b0;
      end
      if (byteValid) begin
        if (!inSector) begin
          reportFailure("byteValid outside of a sector");
        end else begin
          // byte k lands k+1 cycles after the start
          checkValue("byteValid delay", sinceStart, byteIdx + 1);
          if (curIsDir) begin
            checkValue("byteData", byteData, expectedDirByte(byteIdx, dataDone));
            // file size field, little endian
            if (byteIdx >= 28 && byteIdx < 32) begin
              dirLenSeen[8 * (byteIdx - 28) +: 8] = byteData;
            end
          end else if (expQ.size() == 0) begin
            reportFailure("data byte on the port that was never sent");
          end else begin
            checkValue("byteData", byteData, expQ.pop_front());
          end
          byteIdx++;
          if (byteIdx == sectorBytes) begin
            inSector = 1'b0;
            if (curIsDir) begin
              dirLenLog.push_back(dirLenSeen);
            end else begin
              dataDone++;
              dirPending = (dataDone % updateInterval == 0);
            end
          end
        end
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: run stopped after %0d cycles", cycleCount);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  // 8N1 frame, one bit per clksPerBit cycles
  task automatic sendByte(input byteT value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    expQ.push_back(value);
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (clksPerBit - 1) @(posedge clk);
    end
  endtask

  task automatic sendRandom(input int count);
    for (int i = 0; i < count; i++) begin
      sendByte(byteT'($urandom));
    end
  endtask

  task automatic waitSectors(input int dataTarget, input int dirTarget, input int limit);
    int cycles;
    cycles = 0;
    while ((dataDone < dataTarget || dirSeen < dirTarget || inSector) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= limit) reportFailure("expected sectors did not appear in time");
  endtask

  task automatic reportTest(input int num, input string name, input int errsBefore);
    testsRun++;
    if (errorCount == errsBefore) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errorCount - errsBefore);
    end
  endtask

  initial begin
    int errsBefore;
    int startsBefore;
    int cycles;
    void'($urandom(32'h5dd8));
    rx     = 1'b1;
    swRstn = 1'b1;
    while (!porRstn) @(negedge clk);
    repeat (4) @(negedge clk);

    // one full sector
    errsBefore = errorCount;
    sendRandom(sectorBytes);
    waitSectors(1, 0, sectorWaitCycles);
    checkValue("data sector count", dataDone, 1);
    checkValue("sectorStart count", startCount, 1);
    checkValue("bytes still expected", expQ.size(), 0);
    reportTest(1, "one sector", errsBefore);

    // one byte short, nothing may go out
    errsBefore   = errorCount;
    startsBefore = startCount;
    sendRandom(sectorBytes - 1);
    repeat (20 * byteCycles) @(negedge clk);
    checkValue("sectorStart count", startCount, startsBefore);
    reportTest(2, "partial sector", errsBefore);

    // complete sectors 2 to 4
    errsBefore = errorCount;
    sendRandom(2 * sectorBytes + 1);
    waitSectors(4, 2, sectorWaitCycles);
    checkValue("data sector count", dataDone, 4);
    checkValue("bytes still expected", expQ.size(), 0);
    reportTest(3, "consecutive addresses", errsBefore);

    // entry content is compared byte by byte above
    errsBefore = errorCount;
    checkValue("directory sector count", dirSeen, 2);
    if (dirLenLog.size() != 2) begin
      reportFailure("wrong number of directory updates logged");
    end else begin
      checkValue("file length 1", dirLenLog[0], updateInterval * sectorBytes);
      checkValue("file length 2", dirLenLog[1], 2 * updateInterval * sectorBytes);
    end
    reportTest(4, "directory updates", errsBefore);

    // reset halfway through a sector on the port
    errsBefore = errorCount;
    sendRandom(sectorBytes);
    cycles = 0;
    while (!(inSector && byteIdx >= sectorBytes / 2) && cycles < sectorWaitCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= sectorWaitCycles) reportFailure("sector before reset never started");
    @(posedge clk);
    swRstn <= 1'b0;
    repeat (4) @(negedge clk);
    expQ.delete();
    @(posedge clk);
    swRstn <= 1'b1;
    repeat (2) @(negedge clk);
    startsBefore = startCount;
    sendRandom(sectorBytes);
    waitSectors(1, 0, sectorWaitCycles);
    checkValue("data sector count", dataDone, 1);
    checkValue("sectorStart count", startCount - startsBefore, 1);
    checkValue("sectorAddr after reset", lastStartAddr, dataStart);
    checkValue("bytes still expected", expQ.size(), 0);
    reportTest(5, "reset", errsBefore);

    // bound assertion failures count as errors
    errorCount += u_dut.u_sva.failCount;
    $display("summary: %0d tests, %0d checks, %0d errors", testsRun, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/byteFifo.sv ====
// byte FIFO between the UART and the sector writer
// circular buffer with a fill count and a registered read port,
// writes while full are dropped

`timescale 1ns/1ps

module byteFifo
  import loggerPkg::*;
#(
  parameter int fifoDepthLog2 = 11
) (
  input  logic      clk,
  input  logic      rstn,
  input  logic      wrEn,
  input  byteT      wrData,
  input  logic      pop,
  output byteT      popData,
  output fifoCountT fillCount
);

  localparam int        depth     = 2 ** fifoDepthLog2;
  localparam fifoCountT depthFill = fifoCountT'(depth);

  byteT                     mem [depth];
  logic [fifoDepthLog2-1:0] wrPtr;
  logic [fifoDepthLog2-1:0] rdPtr;
  logic                     doWr;
  logic                     doRd;

  // full check uses the level before this cycle's pop
  assign doWr = wrEn && (fillCount != depthFill);
  assign doRd = pop && (fillCount != '0);

  // ------------------------------
  // pointers and level
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
    end else begin
      if (doWr) wrPtr <= wrPtr + 1'b1;
      if (doRd) rdPtr <= rdPtr + 1'b1;
      fillCount <= fillCount + fifoCountT'(doWr) - fifoCountT'(doRd);
    end
  end

  // ------------------------------
  // storage, one cycle read
  // ------------------------------
  always_ff @(posedge clk) begin
    if (doWr) mem[wrPtr] <= wrData;
    if (doRd) popData <= mem[rdPtr];
  end

endmodule

// ==== verilog/sdFileLogger.sv ====
// SD card sector logger, top level
// UART bytes are buffered in a FIFO and streamed out as sector
// writes, with periodic directory entry updates
// pipeline: uartRx -> byteFifo -> sectorWriter

`timescale 1ns/1ps

module sdFileLogger
  import loggerPkg::*;
#(
  parameter int                        clksPerBit      = 22,
  parameter int                        fifoDepthLog2   = 11,
  parameter int                        sectorBytes     = 512,
  parameter sectorAddrT                dataStartSector = 32'h0000_2000,
  parameter sectorAddrT                dirSector       = 32'h0000_1000,
  parameter int                        updateInterval  = 8,
  parameter logic [8*shortNameLen-1:0] shortName       = "SAVEDATADAT",
  parameter logic [31:0]               startCluster    = 32'd5
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rx,
  output logic       sectorStart,
  output sectorAddrT sectorAddr,
  output logic       byteValid,
  output byteT       byteData
);

  logic      rxValid;
  byteT      rxByte;
  logic      pop;
  byteT      popData;
  fifoCountT fillCount;

  // ------------------------------
  // serial input
  // ------------------------------
  uartRx #(
    .clksPerBit(clksPerBit)
  ) u_uartRx (
    .clk    (clk),
    .rstn   (rstn),
    .rx     (rx),
    .rxValid(rxValid),
    .rxByte (rxByte)
  );

  // byte buffer
  byteFifo #(
    .fifoDepthLog2(fifoDepthLog2)
  ) u_byteFifo (
    .clk      (clk),
    .rstn     (rstn),
    .wrEn     (rxValid),
    .wrData   (rxByte),
    .pop      (pop),
    .popData  (popData),
    .fillCount(fillCount)
  );

  // ------------------------------
  // sector output
  // ------------------------------
  sectorWriter #(
    .sectorBytes    (sectorBytes),
    .dataStartSector(dataStartSector),
    .dirSector      (dirSector),
    .updateInterval (updateInterval),
    .shortName      (shortName),
    .startCluster   (startCluster)
  ) u_sectorWriter (
    .clk        (clk),
    .rstn       (rstn),
    .fillCount  (fillCount),
    .popData    (popData),
    .pop        (pop),
    .sectorStart(sectorStart),
    .sectorAddr (sectorAddr),
    .byteValid  (byteValid),
    .byteData   (byteData)
  );

endmodule

// ==== verilog/uartRx.sv ====
// UART receiver, 8N1
// samples each bit at its middle, shifts data in LSB first
// and strobes the byte out once the stop bit checks high

`timescale 1ns/1ps

module uartRx
  import loggerPkg::*;
#(
  parameter int clksPerBit = 22
) (
  input  logic clk,
  input  logic rstn,
  input  logic rx,
  output logic rxValid,
  output byteT rxByte
);

  localparam int cntW = $clog2(clksPerBit + 1);
  localparam logic [cntW-1:0] bitLast  = cntW'(clksPerBit - 1);
  localparam logic [cntW-1:0] halfLast = cntW'(clksPerBit / 2 - 1);

  typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateT;

  rxStateT         state;
  logic [1:0]      rxSync;
  logic [cntW-1:0] clkCnt;
  logic [2:0]      bitIdx;

  // two flop synchronizer, line idles high
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxSync <= 2'b11;
    end else begin
      rxSync <= {rxSync[0], rx};
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= rxIdle;
      clkCnt  <= '0;
      bitIdx  <= '0;
      rxValid <= 1'b0;
      rxByte  <= '0;
    end else begin
      rxValid <= 1'b0;
      clkCnt  <= clkCnt + 1'b1;
      case (state)
        rxIdle: begin
          clkCnt <= '0;
          // falling edge opens a frame
          if (!rxSync[1]) state <= rxStart;
        end
        rxStart: begin
          // half a bit in, start bit must still be low
          if (clkCnt == halfLast) begin
            clkCnt <= '0;
            bitIdx <= '0;
            state  <= rxSync[1] ? rxIdle : rxData;
          end
        end
        rxData: begin
          if (clkCnt == bitLast) begin
            clkCnt <= '0;
            rxByte <= {rxSync[1], rxByte[7:1]};
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) state <= rxStop;
          end
        end
        rxStop: begin
          // low stop bit drops the byte
          if (clkCnt == bitLast) begin
            rxValid <= rxSync[1];
            state   <= rxIdle;
          end
        end
        default: state <= rxIdle;
      endcase
    end
  end

endmodule
